// File: dcache_pkg.sv
/*
 * data cache hit stage shared definitions
 * geometry constants, physical address union, request, exception,
 * memory and BIU response structs, BIU command encoding, write-buffer
 * and evict-buffer entries
 */

package dcache_pkg;

  ////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////
  localparam int unsigned XLEN           = 32;
  localparam int unsigned PLEN           = 32;
  localparam int unsigned BLK_BITS       = 128;
  localparam int unsigned BLK_OFFS_BITS  = 4;
  localparam int unsigned DAT_OFFS_BITS  = 2;
  localparam int unsigned BYTE_OFFS_BITS = BLK_OFFS_BITS - DAT_OFFS_BITS;
  localparam int unsigned IDX_BITS       = 6;
  localparam int unsigned TAG_BITS       = PLEN - IDX_BITS - BLK_OFFS_BITS;

  ////////////////////////////////////////////////////////////////////
  // physical address
  ////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [TAG_BITS-1:0]       tag;
    logic [IDX_BITS-1:0]       idx;
    logic [DAT_OFFS_BITS-1:0]  offs;
    logic [BYTE_OFFS_BITS-1:0] boffs;
  } dcache_adr_t;

  // same word, raw or split into cache fields
  typedef union packed {
    logic [PLEN-1:0] raw;
    dcache_adr_t     fld;
  } dcache_adr_u;

  // request from the previous pipe stage
  typedef struct packed {
    logic                req;
    logic                wreq;
    logic                cacheable;
    dcache_adr_u         adr;
    logic [XLEN/8-1:0]   be;
    logic [XLEN-1:0]     d;
  } dcache_req_t;

  // exception flags that travel with the request
  typedef struct packed {
    logic misaligned;
    logic pma;
    logic pmp;
    logic pagefault;
  } dcache_exc_t;

  // tag and data memory response
  typedef struct packed {
    logic                hit;
    logic                way_dirty;
    logic [BLK_BITS-1:0] line;
  } dcache_mem_rsp_t;

  // BIU read data beat
  typedef struct packed {
    logic [XLEN-1:0] q;
    logic            ack;
    logic            err;
    logic [PLEN-1:0] adro;
  } biu_rsp_t;

  typedef enum logic [1:0] {
    BIUCMD_NOP      = 2'd0,
    BIUCMD_READWAY  = 2'd1,
    BIUCMD_WRITEWAY = 2'd2
  } biucmd_t;

  // be is already aligned to the line
  typedef struct packed {
    logic [IDX_BITS-1:0]      idx;
    logic [DAT_OFFS_BITS-1:0] offs;
    logic [XLEN-1:0]          data;
    logic [BLK_BITS/8-1:0]    be;
  } wb_entry_t;

  typedef struct packed {
    logic [PLEN-1:0]     adr;
    logic [BLK_BITS-1:0] line;
  } evict_t;

endpackage

// File: dcache_req_check.sv
/*
 * request qualification
 * strips faulting requests and registers the
 * access error, misaligned and page-fault outputs
 */

`timescale 1ns/1ns

module dcache_req_check (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  dcache_pkg::dcache_req_t  req_i,
  input  dcache_pkg::dcache_exc_t  exc_i,
  input  logic                     err_bus_i,
  output logic                     valid_req_o,
  output logic                     err_o,
  output logic                     misaligned_o,
  output logic                     pagefault_o
);

  import dcache_pkg::*;

  logic pma_pmp_fault;

  assign pma_pmp_fault = exc_i.pma | exc_i.pmp;

  // only a fault-free request may touch the cache
  assign valid_req_o = req_i.req & ~pma_pmp_fault & ~exc_i.misaligned &
                       ~exc_i.pagefault;

  ////////////////////////////////////////////////////////////////////
  // exception outputs
  ////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_o        <= 1'b0;
      misaligned_o <= 1'b0;
      pagefault_o  <= 1'b0;
    end else begin
      // bus error or pma/pmp access fault
      err_o        <= err_bus_i | (req_i.req & pma_pmp_fault);
      misaligned_o <= req_i.req & exc_i.misaligned;
      pagefault_o  <= exc_i.pagefault;
    end
  end

endmodule

// File: dcache_miss_fsm.sv
/*
 * miss handling state machine
 * registered BIU command, fill way and evict buffer,
 * stall / latchmem control and the registered acknowledge
 */

`timescale 1ns/1ns

module dcache_miss_fsm #(
  parameter int unsigned WAYS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              valid_req_i,
  input  dcache_pkg::dcache_req_t           req_i,
  input  logic                              flush_i,
  input  dcache_pkg::dcache_mem_rsp_t       mem_i,
  input  logic [WAYS-1:0]                   fill_way_i,
  input  logic [dcache_pkg::TAG_BITS-1:0]   evict_tag_i,
  input  logic [dcache_pkg::IDX_BITS-1:0]   evict_idx_i,
  input  logic [dcache_pkg::BLK_BITS-1:0]   evict_line_i,
  input  logic                              biucmd_ack_i,
  input  logic                              biucmd_busy_i,
  input  dcache_pkg::biu_rsp_t              biu_i,
  output logic                              stall_o,
  output logic                              latchmem_o,
  output logic                              ack_o,
  output logic                              armed_o,
  output logic                              filling_o,
  output logic [WAYS-1:0]                   fill_way_o,
  output dcache_pkg::biucmd_t               biucmd_o,
  output dcache_pkg::evict_t                evict_o
);

  import dcache_pkg::*;

  typedef enum logic [2:0] {
    ARMED,
    EVICT,
    READ,
    RECOVER0,
    RECOVER1
  } state_t;

  state_t          state, nxt_state;
  biucmd_t         nxt_biucmd;
  logic [WAYS-1:0] nxt_fill_way;

  logic            cache_miss;
  logic            cache_ack;
  logic            biu_adr_match;
  logic            fill_ack;

  ////////////////////////////////////////////////////////////////////
  // hit / miss qualification
  ////////////////////////////////////////////////////////////////////
  assign cache_miss = valid_req_i & req_i.cacheable & ~mem_i.hit;
  assign cache_ack  = valid_req_i & req_i.cacheable & mem_i.hit & ~flush_i;

  // BIU beat for the word the core is asking for
  assign biu_adr_match = biu_i.adro[PLEN-1:BYTE_OFFS_BITS] ==
                         req_i.adr.raw[PLEN-1:BYTE_OFFS_BITS];
  assign fill_ack = (valid_req_i & biu_i.ack & biu_adr_match & ~flush_i) | cache_ack;

  ////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state    = state;
    nxt_biucmd   = BIUCMD_NOP;
    nxt_fill_way = fill_way_o;

    case (state)
      ARMED: begin
        if (cache_miss && !flush_i && !biucmd_busy_i) begin
          // refill the same way the victim came from
          nxt_fill_way = fill_way_i;
          nxt_biucmd   = BIUCMD_READWAY;
          nxt_state    = mem_i.way_dirty ? EVICT : READ;
        end
      end

      // new line is read first, victim written back afterwards
      EVICT: begin
        if (biucmd_ack_i || biu_i.err) begin
          nxt_biucmd = BIUCMD_WRITEWAY;
          nxt_state  = RECOVER0;
        end
      end

      READ: begin
        if (biucmd_ack_i || biu_i.err) begin
          nxt_state = RECOVER0;
        end
      end

      // set up idx for tag/data memory
      RECOVER0: nxt_state = RECOVER1;

      // memory outputs valid again
      RECOVER1: nxt_state = ARMED;

      default: nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state      <= ARMED;
      biucmd_o   <= BIUCMD_NOP;
      fill_way_o <= '0;
      armed_o    <= 1'b1;
      filling_o  <= 1'b0;
    end else begin
      state      <= nxt_state;
      biucmd_o   <= nxt_biucmd;
      fill_way_o <= nxt_fill_way;
      armed_o    <= (nxt_state == ARMED);
      filling_o  <= (nxt_state == READ) | (nxt_state == EVICT);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // evict buffer
  ////////////////////////////////////////////////////////////////////
  // victim is held here so memory can move on
  always_ff @(posedge clk_i) begin
    if (state == ARMED) begin
      evict_o.adr  <= {evict_tag_i, evict_idx_i, {BLK_OFFS_BITS{1'b0}}};
      evict_o.line <= evict_line_i;
    end
  end

  // stall and memory latch
  always_comb begin
    case (state)
      ARMED: begin
        stall_o    = cache_miss;
        latchmem_o = ~cache_miss;
      end
      READ, EVICT: begin
        stall_o    = ~(fill_ack | (valid_req_i & mem_i.hit));
        latchmem_o = fill_ack | (valid_req_i & mem_i.hit);
      end
      RECOVER0: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b0;
      end
      RECOVER1: begin
        stall_o    = 1'b1;
        latchmem_o = 1'b1;
      end
      default: begin
        stall_o    = 1'b0;
        latchmem_o = 1'b1;
      end
    endcase
  end

  // data ready downstream
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
    end else begin
      case (state)
        ARMED:       ack_o <= cache_ack;
        READ, EVICT: ack_o <= fill_ack;
        default:     ack_o <= 1'b0;
      endcase
    end
  end

endmodule

// File: dcache_store_buffer.sv
/*
 * one-entry write buffer
 * captured on a cacheable store hit, held until acknowledged
 */

`timescale 1ns/1ns

module dcache_store_buffer #(
  parameter int unsigned WAYS = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    valid_req_i,
  input  dcache_pkg::dcache_req_t req_i,
  input  logic                    hit_i,
  input  logic [WAYS-1:0]         ways_hit_i,
  input  logic                    flush_i,
  input  logic                    writebuffer_ack_i,
  output logic                    wb_we_o,
  output dcache_pkg::wb_entry_t   wb_o,
  output logic [WAYS-1:0]         wb_ways_hit_o
);

  import dcache_pkg::*;

  logic                   store_hit;
  logic [BLK_BITS/8-1:0]  line_be;

  assign store_hit = valid_req_i & req_i.wreq & req_i.cacheable & hit_i;

  // word byte enables moved to their place in the line
  assign line_be = (BLK_BITS/8)'(req_i.be) << {req_i.adr.fld.offs, 2'b00};

  ////////////////////////////////////////////////////////////////////
  // write enable
  ////////////////////////////////////////////////////////////////////
  // flush wins, a new store keeps we high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_o <= 1'b0;
    end else if (flush_i) begin
      wb_we_o <= 1'b0;
    end else if (store_hit) begin
      wb_we_o <= 1'b1;
    end else if (writebuffer_ack_i) begin
      wb_we_o <= 1'b0;
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (store_hit) begin
      wb_o.idx      <= req_i.adr.fld.idx;
      wb_o.offs     <= req_i.adr.fld.offs;
      wb_o.data     <= req_i.d;
      wb_o.be       <= line_be;
      wb_ways_hit_o <= ways_hit_i;
    end
  end

endmodule

// File: dcache_load_align.sv
/*
 * load data path
 * write-buffer bypass into the line, word select and q register
 */

`timescale 1ns/1ns

module dcache_load_align (
  input  logic                          clk_i,
  input  dcache_pkg::dcache_req_t       req_i,
  input  dcache_pkg::dcache_mem_rsp_t   mem_i,
  input  logic [dcache_pkg::XLEN-1:0]   biu_q_i,
  input  logic                          wb_we_i,
  input  dcache_pkg::wb_entry_t         wb_i,
  output logic [dcache_pkg::XLEN-1:0]   q_o
);

  import dcache_pkg::*;

  localparam int unsigned WORD_BYTES = XLEN / 8;

  logic                bypass;
  logic [BLK_BITS-1:0] merged_line;
  logic [XLEN-1:0]     line_word;

  // pending store to the same set
  assign bypass = wb_we_i & (req_i.adr.fld.idx == wb_i.idx);

  ////////////////////////////////////////////////////////////////////
  // byte merge
  ////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < BLK_BITS/8; i++) begin
      if (bypass && wb_i.be[i]) begin
        // write data replicated over every word of the line
        merged_line[i*8 +: 8] = wb_i.data[(i % WORD_BYTES)*8 +: 8];
      end else begin
        merged_line[i*8 +: 8] = mem_i.line[i*8 +: 8];
      end
    end
  end

  // word at the request offset
  assign line_word = merged_line[req_i.adr.fld.offs*XLEN +: XLEN];

  // biu data on a miss
  always_ff @(posedge clk_i) begin
    if (mem_i.hit) begin
      q_o <= line_word;
    end else begin
      q_o <= biu_q_i;
    end
  end

endmodule

// File: dcache_hit_top.sv
/*
 * data cache hit stage top level
 * request check, miss FSM, write buffer and load path
 */

`timescale 1ns/1ns

module dcache_hit_top #(
  parameter int unsigned WAYS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  // core side
  input  dcache_pkg::dcache_req_t           req_i,
  input  dcache_pkg::dcache_exc_t           exc_i,
  input  logic                              flush_i,
  output logic                              stall_o,
  output logic                              ack_o,
  output logic [dcache_pkg::XLEN-1:0]       q_o,
  output logic                              err_o,
  output logic                              misaligned_o,
  output logic                              pagefault_o,

  // tag and data memory
  input  dcache_pkg::dcache_mem_rsp_t       mem_i,
  input  logic [WAYS-1:0]                   ways_hit_i,
  input  logic [WAYS-1:0]                   fill_way_i,
  input  logic [dcache_pkg::TAG_BITS-1:0]   evict_tag_i,
  input  logic [dcache_pkg::IDX_BITS-1:0]   evict_idx_i,
  input  logic [dcache_pkg::BLK_BITS-1:0]   evict_line_i,
  output logic                              latchmem_o,
  output logic [dcache_pkg::IDX_BITS-1:0]   idx_o,
  output logic [dcache_pkg::TAG_BITS-1:0]   core_tag_o,
  output logic                              armed_o,
  output logic                              filling_o,
  output logic [WAYS-1:0]                   fill_way_o,

  // BIU
  input  logic                              biucmd_ack_i,
  input  logic                              biucmd_busy_i,
  input  dcache_pkg::biu_rsp_t              biu_i,
  output dcache_pkg::biucmd_t               biucmd_o,
  output dcache_pkg::evict_t                evict_o,

  // write buffer
  input  logic                              writebuffer_ack_i,
  output logic                              wb_we_o,
  output dcache_pkg::wb_entry_t             wb_o,
  output logic [WAYS-1:0]                   wb_ways_hit_o
);

  import dcache_pkg::*;

  logic      valid_req;
  logic      wb_we;
  wb_entry_t wb_entry;

  // tag/data memory address for writing
  assign idx_o      = req_i.adr.fld.idx;
  assign core_tag_o = req_i.adr.fld.tag;

  assign wb_we_o = wb_we;
  assign wb_o    = wb_entry;

  dcache_req_check u_req_check (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .exc_i        (exc_i),
    .err_bus_i    (biu_i.err),
    .valid_req_o  (valid_req),
    .err_o        (err_o),
    .misaligned_o (misaligned_o),
    .pagefault_o  (pagefault_o)
  );

  dcache_miss_fsm #(.WAYS(WAYS)) u_miss_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_req_i   (valid_req),
    .req_i         (req_i),
    .flush_i       (flush_i),
    .mem_i         (mem_i),
    .fill_way_i    (fill_way_i),
    .evict_tag_i   (evict_tag_i),
    .evict_idx_i   (evict_idx_i),
    .evict_line_i  (evict_line_i),
    .biucmd_ack_i  (biucmd_ack_i),
    .biucmd_busy_i (biucmd_busy_i),
    .biu_i         (biu_i),
    .stall_o       (stall_o),
    .latchmem_o    (latchmem_o),
    .ack_o         (ack_o),
    .armed_o       (armed_o),
    .filling_o     (filling_o),
    .fill_way_o    (fill_way_o),
    .biucmd_o      (biucmd_o),
    .evict_o       (evict_o)
  );

  dcache_store_buffer #(.WAYS(WAYS)) u_store_buffer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .valid_req_i       (valid_req),
    .req_i             (req_i),
    .hit_i             (mem_i.hit),
    .ways_hit_i        (ways_hit_i),
    .flush_i           (flush_i),
    .writebuffer_ack_i (writebuffer_ack_i),
    .wb_we_o           (wb_we),
    .wb_o              (wb_entry),
    .wb_ways_hit_o     (wb_ways_hit_o)
  );

  dcache_load_align u_load_align (
    .clk_i   (clk_i),
    .req_i   (req_i),
    .mem_i   (mem_i),
    .biu_q_i (biu_i.q),
    .wb_we_i (wb_we),
    .wb_i    (wb_entry),
    .q_o     (q_o)
  );

endmodule

// File: dcache_hit_properties.sv
/*
 * concurrent assertions on the hit stage ports
 * write-buffer release, memory latch and BIU command rules
 */

`timescale 1ns/1ns

module dcache_hit_properties (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                wb_we_o,
  input logic                writebuffer_ack_i,
  input logic                flush_i,
  input logic                stall_o,
  input logic                latchmem_o,
  input logic                armed_o,
  input dcache_pkg::biucmd_t biucmd_o
);

  import dcache_pkg::*;

  int unsigned fail_count = 0;

  // write buffer is only released by its ack or a pipe flush
  wb_release_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(wb_we_o) |-> ($past(writebuffer_ack_i) || $past(flush_i)))
  else begin
    fail_count++;
    $error("wb_we_o fell without writebuffer_ack_i or flush_i");
  end

  // memory latches whenever the pipe moves
  latchmem_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    armed_o |-> (latchmem_o == !stall_o))
  else begin
    fail_count++;
    $error("latchmem_o is not the inverse of stall_o while armed");
  end

  // victim write-back belongs to a miss
  no_writeway_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    armed_o |-> (biucmd_o != BIUCMD_WRITEWAY))
  else begin
    fail_count++;
    $error("WRITEWAY command issued while armed");
  end

endmodule

bind dcache_hit_top dcache_hit_properties u_props (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .wb_we_o           (wb_we_o),
  .writebuffer_ack_i (writebuffer_ack_i),
  .flush_i           (flush_i),
  .stall_o           (stall_o),
  .latchmem_o        (latchmem_o),
  .armed_o           (armed_o),
  .biucmd_o          (biucmd_o)
);

// File: tb_dcache_hit.sv
/*
 * testbench for the data cache hit stage
 * clock, reset, memory and BIU inputs driven per test,
 * value check task and directed tests
 */

`timescale 1ns/1ns

module tb_dcache_hit;

  import dcache_pkg::*;

  localparam int unsigned WAYS    = 2;
  localparam int unsigned TIMEOUT = 20;

  logic                  clk_i;
  logic                  rst_ni;
  dcache_req_t           req_i;
  dcache_exc_t           exc_i;
  logic                  flush_i;
  logic                  stall_o;
  logic                  ack_o;
  logic [XLEN-1:0]       q_o;
  logic                  err_o;
  logic                  misaligned_o;
  logic                  pagefault_o;
  dcache_mem_rsp_t       mem_i;
  logic [WAYS-1:0]       ways_hit_i;
  logic [WAYS-1:0]       fill_way_i;
  logic [TAG_BITS-1:0]   evict_tag_i;
  logic [IDX_BITS-1:0]   evict_idx_i;
  logic [BLK_BITS-1:0]   evict_line_i;
  logic                  latchmem_o;
  logic [IDX_BITS-1:0]   idx_o;
  logic [TAG_BITS-1:0]   core_tag_o;
  logic                  armed_o;
  logic                  filling_o;
  logic [WAYS-1:0]       fill_way_o;
  logic                  biucmd_ack_i;
  logic                  biucmd_busy_i;
  biu_rsp_t              biu_i;
  biucmd_t               biucmd_o;
  evict_t                evict_o;
  logic                  writebuffer_ack_i;
  logic                  wb_we_o;
  wb_entry_t             wb_o;
  logic [WAYS-1:0]       wb_ways_hit_o;

  integer seed;

  dcache_hit_top #(.WAYS(WAYS)) dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // stop at the first assertion failure in the bound checker
  always @(dut0.u_props.fail_count) begin
    if (dut0.u_props.fail_count != 0) begin
      $display("Test failed");
      $fatal(1, "assertion failure in the bound checker");
    end
  end

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////
  task automatic check(input string name, input logic [127:0] actual,
                       input logic [127:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual,
               expected);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("Test failed");
    $fatal(1, "wait timed out");
  endtask

  function automatic logic [BLK_BITS-1:0] random_line();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  function automatic logic [XLEN-1:0] word_at(input logic [BLK_BITS-1:0] line,
                                              input logic [1:0] offs);
    return line[offs*XLEN +: XLEN];
  endfunction

  // waits at falling edges for a BIU command
  task automatic wait_for_cmd(input biucmd_t cmd);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (biucmd_o !== cmd) begin
      cycles++;
      if (cycles > TIMEOUT) give_up("a BIU command");
      @(negedge clk_i);
    end
  endtask

  task automatic wait_for_armed();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (armed_o !== 1'b1) begin
      cycles++;
      if (cycles > TIMEOUT) give_up("the miss FSM to return to armed");
      @(negedge clk_i);
    end
  endtask

  task automatic drive_idle();
    req_i.req         <= 1'b0;
    req_i.wreq        <= 1'b0;
    exc_i             <= '0;
    mem_i.hit         <= 1'b0;
    mem_i.way_dirty   <= 1'b0;
    biu_i.ack         <= 1'b0;
    biucmd_ack_i      <= 1'b0;
    writebuffer_ack_i <= 1'b0;
    flush_i           <= 1'b0;
  endtask

  task automatic drive_req(input logic wreq, input logic [31:0] adr, input logic [3:0] be,
                           input logic [31:0] d, input logic hit, input logic dirty,
                           input logic [BLK_BITS-1:0] line);
    req_i.req       <= 1'b1;
    req_i.wreq      <= wreq;
    req_i.cacheable <= 1'b1;
    req_i.adr.raw   <= adr;
    req_i.be        <= be;
    req_i.d         <= d;
    mem_i.hit       <= hit;
    mem_i.way_dirty <= dirty;
    mem_i.line      <= line;
  endtask

  ////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////
  task automatic test_reset_state();
    @(negedge clk_i);
    check("armed_o", armed_o, 1'b1);
    check("stall_o", stall_o, 1'b0);
    check("ack_o", ack_o, 1'b0);
    check("wb_we_o", wb_we_o, 1'b0);
    check("biucmd_o", biucmd_o, BIUCMD_NOP);
  endtask

  task automatic test_load_hit();
    logic [BLK_BITS-1:0] line;
    logic [31:0]         adr;
    line = random_line();
    adr  = $random(seed);
    adr[1:0] = 2'b00;
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b1, 1'b0, line);
    ways_hit_i <= 2'b01;
    @(negedge clk_i);
    check("stall_o", stall_o, 1'b0);
    check("idx_o", idx_o, adr[9:4]);
    check("core_tag_o", core_tag_o, adr[31:10]);
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check("ack_o", ack_o, 1'b1);
    check("q_o", q_o, word_at(line, adr[3:2]));
  endtask

  task automatic test_store_bypass();
    logic [BLK_BITS-1:0] line;
    logic [31:0]         adr;
    logic [31:0]         data;
    logic [31:0]         expected;
    logic [15:0]         line_be;
    logic [3:0]          be;
    int                  b;
    line = random_line();
    adr  = $random(seed);
    adr[1:0] = 2'b00;
    data = $random(seed);
    be   = 4'b0101;
    line_be = 16'(be) << (4 * adr[3:2]);
    expected = word_at(line, adr[3:2]);
    for (b = 0; b < 4; b++) begin
      if (be[b]) expected[b*8 +: 8] = data[b*8 +: 8];
    end
    @(posedge clk_i);
    drive_req(1'b1, adr, be, data, 1'b1, 1'b0, line);
    ways_hit_i <= 2'b10;
    // load to the same word while the store is pending
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b1, 1'b0, line);
    @(negedge clk_i);
    check("wb_we_o", wb_we_o, 1'b1);
    check("wb_o.idx", wb_o.idx, adr[9:4]);
    check("wb_o.offs", wb_o.offs, adr[3:2]);
    check("wb_o.data", wb_o.data, data);
    check("wb_o.be", wb_o.be, line_be);
    check("wb_ways_hit_o", wb_ways_hit_o, 2'b10);
    @(posedge clk_i);
    drive_idle();
    writebuffer_ack_i <= 1'b1;
    @(negedge clk_i);
    check("ack_o", ack_o, 1'b1);
    check("q_o", q_o, expected);
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b0;
    @(negedge clk_i);
    check("wb_we_o", wb_we_o, 1'b0);
  endtask

  task automatic test_clean_miss();
    logic [31:0] adr;
    logic [31:0] beat;
    adr  = $random(seed);
    adr[1:0] = 2'b00;
    beat = $random(seed);
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b0, 1'b0, random_line());
    fill_way_i <= 2'b10;
    @(negedge clk_i);
    check("stall_o", stall_o, 1'b1);
    check("latchmem_o", latchmem_o, 1'b0);
    wait_for_cmd(BIUCMD_READWAY);
    check("fill_way_o", fill_way_o, 2'b10);
    check("filling_o", filling_o, 1'b1);
    // BIU returns the requested word
    @(posedge clk_i);
    biu_i.ack  <= 1'b1;
    biu_i.adro <= adr;
    biu_i.q    <= beat;
    @(negedge clk_i);
    check("biucmd_o", biucmd_o, BIUCMD_NOP);
    @(posedge clk_i);
    biu_i.ack <= 1'b0;
    @(negedge clk_i);
    check("ack_o", ack_o, 1'b1);
    check("q_o", q_o, beat);
    @(posedge clk_i);
    drive_idle();
    biucmd_ack_i <= 1'b1;
    @(posedge clk_i);
    biucmd_ack_i <= 1'b0;
    @(negedge clk_i);
    check("stall_o", stall_o, 1'b1);
    check("latchmem_o", latchmem_o, 1'b0);
    check("armed_o", armed_o, 1'b0);
    @(negedge clk_i);
    check("stall_o", stall_o, 1'b1);
    check("latchmem_o", latchmem_o, 1'b1);
    @(negedge clk_i);
    check("armed_o", armed_o, 1'b1);
  endtask

  task automatic test_dirty_miss();
    logic [31:0]         adr;
    logic [TAG_BITS-1:0] tag;
    logic [IDX_BITS-1:0] idx;
    logic [BLK_BITS-1:0] eline;
    adr   = $random(seed);
    tag   = TAG_BITS'($random(seed));
    idx   = IDX_BITS'($random(seed));
    eline = random_line();
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b0, 1'b1, random_line());
    evict_tag_i  <= tag;
    evict_idx_i  <= idx;
    evict_line_i <= eline;
    wait_for_cmd(BIUCMD_READWAY);
    check("evict_o.adr", evict_o.adr, {tag, idx, 4'b0000});
    check("evict_o.line", evict_o.line, eline);
    @(negedge clk_i);
    check("biucmd_o", biucmd_o, BIUCMD_NOP);
    @(posedge clk_i);
    drive_idle();
    biucmd_ack_i <= 1'b1;
    @(posedge clk_i);
    biucmd_ack_i <= 1'b0;
    @(negedge clk_i);
    check("biucmd_o", biucmd_o, BIUCMD_WRITEWAY);
    wait_for_armed();
  endtask

  task automatic test_exceptions_flush();
    logic [31:0]         adr;
    logic [BLK_BITS-1:0] line;
    adr  = $random(seed);
    adr[1:0] = 2'b00;
    line = random_line();
    // misaligned load that would miss
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b0, 1'b0, line);
    exc_i.misaligned <= 1'b1;
    @(negedge clk_i);
    check("stall_o", stall_o, 1'b0);
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check("misaligned_o", misaligned_o, 1'b1);
    check("err_o", err_o, 1'b0);
    // pma fault on a load that would hit
    @(posedge clk_i);
    drive_req(1'b0, adr, 4'hf, '0, 1'b1, 1'b0, line);
    exc_i.pma <= 1'b1;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check("err_o", err_o, 1'b1);
    check("misaligned_o", misaligned_o, 1'b0);
    check("ack_o", ack_o, 1'b0);
    // page fault on a store that would hit
    @(posedge clk_i);
    drive_req(1'b1, adr, 4'hf, $random(seed), 1'b1, 1'b0, line);
    exc_i.pagefault <= 1'b1;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check("pagefault_o", pagefault_o, 1'b1);
    check("err_o", err_o, 1'b0);
    check("ack_o", ack_o, 1'b0);
    check("wb_we_o", wb_we_o, 1'b0);
    // pending store cancelled by a pipe flush
    @(posedge clk_i);
    drive_req(1'b1, adr, 4'hf, $random(seed), 1'b1, 1'b0, line);
    @(posedge clk_i);
    drive_idle();
    flush_i <= 1'b1;
    @(negedge clk_i);
    check("wb_we_o", wb_we_o, 1'b1);
    @(posedge clk_i);
    flush_i <= 1'b0;
    @(negedge clk_i);
    check("wb_we_o", wb_we_o, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    seed              = 32'h1eac05f7;
    rst_ni            = 1'b0;
    req_i             = '0;
    exc_i             = '0;
    flush_i           = 1'b0;
    mem_i             = '0;
    ways_hit_i        = '0;
    fill_way_i        = '0;
    evict_tag_i       = '0;
    evict_idx_i       = '0;
    evict_line_i      = '0;
    biucmd_ack_i      = 1'b0;
    biucmd_busy_i     = 1'b0;
    biu_i             = '0;
    writebuffer_ack_i = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset_state();
    test_load_hit();
    test_store_bypass();
    test_clean_miss();
    test_dirty_miss();
    test_exceptions_flush();

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    if (dut0.u_props.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "%0d assertion failures", dut0.u_props.fail_count);
    end
  end

endmodule

// File: dcache_hit_top.f
dcache_pkg.sv
dcache_req_check.sv
dcache_miss_fsm.sv
dcache_store_buffer.sv
dcache_load_align.sv
dcache_hit_top.sv
dcache_hit_properties.sv
tb_dcache_hit.sv
